// File: rtl/serial_pkg.sv
package serial_pkg;

	// Link geometry
	localparam int NUM_CHANNELS = 4;
	localparam int CHAN_BITS = 2; // Holds a channel number 0 .. NUM_CHANNELS-1
	localparam int CHAR_BITS = 8;

	// Serial timing, fixed at build time
	localparam int BIT_TICKS = 16; // Clock cycles per serial bit
	localparam int TICK_BITS = 4;
	localparam int FRAME_BITS = 10; // Start bit, eight data bits, stop bit
	localparam int FRAME_CNT_BITS = 4;

	localparam logic [TICK_BITS-1:0] TICK_LAST = TICK_BITS'(BIT_TICKS - 1);
	localparam logic [TICK_BITS-1:0] TICK_MID = TICK_BITS'(BIT_TICKS / 2 - 1); // Mid-bit sample
	localparam logic [FRAME_CNT_BITS-1:0] FRAME_LAST = FRAME_CNT_BITS'(FRAME_BITS - 1);
	localparam logic [FRAME_CNT_BITS-1:0] CHAR_LAST = FRAME_CNT_BITS'(CHAR_BITS - 1);

	// Receive buffer memory
	localparam int RX_DEPTH = 16;
	localparam int RX_ADDR_BITS = 4;
	localparam int RX_COUNT_BITS = RX_ADDR_BITS + 1; // One extra bit so a full buffer is countable
	localparam int ENTRY_BITS = CHAN_BITS + CHAR_BITS; // Channel tag above the character
	localparam logic [RX_COUNT_BITS-1:0] RX_FULL = RX_COUNT_BITS'(RX_DEPTH);

	// Dispatcher handshake states
	localparam logic [1:0] DSP_IDLE = 2'd0;
	localparam logic [1:0] DSP_LOADED = 2'd1;
	localparam logic [1:0] DSP_WAIT_DROP = 2'd2;

	// Receiver frame states
	localparam logic [1:0] RX_IDLE = 2'd0;
	localparam logic [1:0] RX_START = 2'd1;
	localparam logic [1:0] RX_DATA = 2'd2;
	localparam logic [1:0] RX_STOP = 2'd3;

endpackage

// File: rtl/tx_dispatch.sv
`timescale 1ns/1ns

module tx_dispatch (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 tx_req,
	input  logic [serial_pkg::CHAN_BITS-1:0]     tx_channel,
	input  logic [serial_pkg::CHAR_BITS-1:0]     tx_char,
	input  logic [serial_pkg::NUM_CHANNELS-1:0]  busy,
	output logic                                 tx_ack,
	output logic [serial_pkg::NUM_CHANNELS-1:0]  load,
	output logic [serial_pkg::CHAR_BITS-1:0]     load_char
);

	logic [1:0] state;
	logic target_free;
	logic take_req;
	logic [serial_pkg::NUM_CHANNELS-1:0] target_sel;

	assign target_free = ~busy[tx_channel]; // Request waits here while the channel is sending
	assign take_req = (state == serial_pkg::DSP_IDLE) && tx_req && target_free;

	// One-hot select of the addressed channel
	always_comb begin
		target_sel = '0;
		target_sel[tx_channel] = 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= serial_pkg::DSP_IDLE;
			load <= '0;
			tx_ack <= 1'b0;
		end else begin
			case (state)
				serial_pkg::DSP_IDLE: begin
					if (take_req) begin
						load <= target_sel; // Strobe lasts exactly one cycle
						state <= serial_pkg::DSP_LOADED;
					end
				end
				serial_pkg::DSP_LOADED: begin
					load <= '0;
					tx_ack <= 1'b1; // Ack follows the load strobe by one cycle
					state <= serial_pkg::DSP_WAIT_DROP;
				end
				serial_pkg::DSP_WAIT_DROP: begin
					if (!tx_req) begin
						tx_ack <= 1'b0;
						state <= serial_pkg::DSP_IDLE;
					end
				end
				default: begin
					load <= '0;
					tx_ack <= 1'b0;
					state <= serial_pkg::DSP_IDLE;
				end
			endcase
		end
	end

	// The character rides along with the load strobe on a shared bus
	always_ff @(posedge clk) begin
		if (take_req) begin
			load_char <= tx_char;
		end
	end

endmodule

// File: rtl/serial_channel.sv
`timescale 1ns/1ns

module serial_channel (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              load,
	input  logic [serial_pkg::CHAR_BITS-1:0]  load_char,
	input  logic                              serial_in,
	output logic                              busy,
	output logic                              serial_out,
	output logic                              rx_valid,
	output logic [serial_pkg::CHAR_BITS-1:0]  rx_char,
	output logic                              frame_err
);

	// Transmitter
	logic [serial_pkg::FRAME_BITS-1:0] tx_frame;
	logic [serial_pkg::TICK_BITS-1:0] tx_tick;
	logic [serial_pkg::FRAME_CNT_BITS-1:0] tx_bit;
	logic tx_bit_end;

	// Receiver
	logic rx_sync1;
	logic rx_sync2;
	logic rx_prev;
	logic [1:0] rx_state;
	logic [serial_pkg::TICK_BITS-1:0] rx_tick;
	logic [serial_pkg::FRAME_CNT_BITS-1:0] rx_bit;
	logic [serial_pkg::CHAR_BITS-1:0] rx_shift;
	logic rx_bit_end;

	assign tx_bit_end = (tx_tick == serial_pkg::TICK_LAST);
	assign serial_out = tx_frame[0]; // Frame register shifts out LSB first

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_frame <= '1; // Idle line is high
			tx_tick <= '0;
			tx_bit <= '0;
			busy <= 1'b0;
		end else if (load) begin
			tx_frame <= {1'b1, load_char, 1'b0}; // Stop, data, start
			tx_tick <= '0;
			tx_bit <= '0;
			busy <= 1'b1;
		end else if (busy) begin
			if (tx_bit_end) begin
				tx_tick <= '0;
				tx_frame <= {1'b1, tx_frame[serial_pkg::FRAME_BITS-1:1]}; // Refill with idle ones
				tx_bit <= tx_bit + 1'b1;
				if (tx_bit == serial_pkg::FRAME_LAST) begin
					busy <= 1'b0; // Stop bit has run its full period
				end
			end else begin
				tx_tick <= tx_tick + 1'b1;
			end
		end
	end

	// Two flops against metastability, a third to see the falling edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_sync1 <= 1'b1;
			rx_sync2 <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_sync1 <= serial_in;
			rx_sync2 <= rx_sync1;
			rx_prev <= rx_sync2;
		end
	end

	assign rx_bit_end = (rx_tick == serial_pkg::TICK_LAST);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_state <= serial_pkg::RX_IDLE;
			rx_tick <= '0;
			rx_bit <= '0;
			rx_valid <= 1'b0;
			frame_err <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			frame_err <= 1'b0;
			case (rx_state)
				serial_pkg::RX_IDLE: begin
					rx_tick <= '0;
					if (rx_prev && !rx_sync2) begin
						rx_state <= serial_pkg::RX_START;
					end
				end
				serial_pkg::RX_START: begin
					if (rx_tick == serial_pkg::TICK_MID) begin
						rx_tick <= '0;
						rx_bit <= '0;
						// A start bit gone high by mid-bit was only a glitch
						rx_state <= rx_sync2 ? serial_pkg::RX_IDLE : serial_pkg::RX_DATA;
					end else begin
						rx_tick <= rx_tick + 1'b1;
					end
				end
				serial_pkg::RX_DATA: begin
					if (rx_bit_end) begin
						rx_tick <= '0;
						rx_bit <= rx_bit + 1'b1;
						if (rx_bit == serial_pkg::CHAR_LAST) begin
							rx_state <= serial_pkg::RX_STOP;
						end
					end else begin
						rx_tick <= rx_tick + 1'b1;
					end
				end
				serial_pkg::RX_STOP: begin
					if (rx_bit_end) begin
						rx_valid <= rx_sync2; // Good stop bit delivers the character
						frame_err <= ~rx_sync2;
						rx_state <= serial_pkg::RX_IDLE;
					end else begin
						rx_tick <= rx_tick + 1'b1;
					end
				end
				default: begin
					rx_state <= serial_pkg::RX_IDLE;
				end
			endcase
		end
	end

	// Data arrives LSB first, so it enters at the top and moves down
	always_ff @(posedge clk) begin
		if (rx_state == serial_pkg::RX_DATA && rx_bit_end) begin
			rx_shift <= {rx_sync2, rx_shift[serial_pkg::CHAR_BITS-1:1]};
		end
		if (rx_state == serial_pkg::RX_STOP && rx_bit_end) begin
			rx_char <= rx_shift; // Updates in the same edge that raises rx_valid
		end
	end

endmodule

// File: rtl/rx_collector.sv
`timescale 1ns/1ns

module rx_collector (
	input  logic                                                         clk,
	input  logic                                                         rst_n,
	input  logic [serial_pkg::NUM_CHANNELS-1:0]                          rx_valid,
	input  logic [serial_pkg::NUM_CHANNELS-1:0][serial_pkg::CHAR_BITS-1:0] rx_char,
	input  logic                                                         rd_req,
	output logic                                                         rd_ack,
	output logic [serial_pkg::CHAN_BITS-1:0]                             rd_channel,
	output logic [serial_pkg::CHAR_BITS-1:0]                             rd_char,
	output logic                                                         overrun
);

	logic [serial_pkg::NUM_CHANNELS-1:0] pend_valid;
	logic [serial_pkg::NUM_CHANNELS-1:0][serial_pkg::CHAR_BITS-1:0] pend_char;
	logic [serial_pkg::CHAN_BITS-1:0] rr_ptr;
	logic [serial_pkg::CHAN_BITS-1:0] scan_chan;
	logic [serial_pkg::CHAN_BITS-1:0] grant_chan;
	logic grant_found;
	logic [serial_pkg::NUM_CHANNELS-1:0] grant_clear;
	logic wr_en;
	logic rd_free;

	logic [serial_pkg::ENTRY_BITS-1:0] buf_mem [serial_pkg::RX_DEPTH];
	logic [serial_pkg::RX_ADDR_BITS-1:0] wr_ptr;
	logic [serial_pkg::RX_ADDR_BITS-1:0] rd_ptr;
	logic [serial_pkg::RX_COUNT_BITS-1:0] rx_count;

	// Round-robin scan starting at rr_ptr, first pending channel wins
	always_comb begin
		grant_found = 1'b0;
		grant_chan = '0;
		scan_chan = rr_ptr;
		for (int k = 0; k < serial_pkg::NUM_CHANNELS; k++) begin
			scan_chan = rr_ptr + k[serial_pkg::CHAN_BITS-1:0];
			if (!grant_found && pend_valid[scan_chan]) begin
				grant_found = 1'b1;
				grant_chan = scan_chan;
			end
		end
	end

	assign wr_en = grant_found && (rx_count != serial_pkg::RX_FULL); // Full buffer holds them back
	assign rd_free = rd_ack && !rd_req;

	always_comb begin
		grant_clear = '0;
		grant_clear[grant_chan] = wr_en;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pend_valid <= '0;
			overrun <= 1'b0;
		end else begin
			for (int i = 0; i < serial_pkg::NUM_CHANNELS; i++) begin
				if (rx_valid[i] && pend_valid[i] && !grant_clear[i]) begin
					overrun <= 1'b1; // Sticky, the new character is dropped
				end else if (rx_valid[i]) begin
					pend_valid[i] <= 1'b1;
				end else if (grant_clear[i]) begin
					pend_valid[i] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < serial_pkg::NUM_CHANNELS; i++) begin
			if (rx_valid[i] && (!pend_valid[i] || grant_clear[i])) begin
				pend_char[i] <= rx_char[i];
			end
		end
		if (wr_en) begin
			buf_mem[wr_ptr] <= {grant_chan, pend_char[grant_chan]};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rr_ptr <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			rx_count <= '0;
			rd_ack <= 1'b0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
				rr_ptr <= grant_chan + 1'b1; // Next scan starts past the winner
			end
			if (rd_free) begin
				rd_ack <= 1'b0;
				rd_ptr <= rd_ptr + 1'b1; // Entry is released once the host lets go
			end else if (rd_req && !rd_ack && rx_count != '0) begin
				rd_ack <= 1'b1;
			end
			case ({wr_en, rd_free})
				2'b10: rx_count <= rx_count + 1'b1;
				2'b01: rx_count <= rx_count - 1'b1;
				default: rx_count <= rx_count;
			endcase
		end
	end

	// Head entry stays put while rd_ack is high
	assign {rd_channel, rd_char} = buf_mem[rd_ptr];

endmodule

// File: rtl/serial_comm_top.sv
`timescale 1ns/1ns

module serial_comm_top (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 tx_req,
	input  logic [serial_pkg::CHAN_BITS-1:0]     tx_channel,
	input  logic [serial_pkg::CHAR_BITS-1:0]     tx_char,
	input  logic [serial_pkg::NUM_CHANNELS-1:0]  serial_in,
	input  logic                                 rd_req,
	output logic                                 tx_ack,
	output logic                                 rd_ack,
	output logic [serial_pkg::CHAN_BITS-1:0]     rd_channel,
	output logic [serial_pkg::CHAR_BITS-1:0]     rd_char,
	output logic [serial_pkg::NUM_CHANNELS-1:0]  serial_out,
	output logic                                 frame_err,
	output logic                                 overrun
);

	logic [serial_pkg::NUM_CHANNELS-1:0] busy;
	logic [serial_pkg::NUM_CHANNELS-1:0] load;
	logic [serial_pkg::CHAR_BITS-1:0] load_char; // Shared by all channels, load picks one
	logic [serial_pkg::NUM_CHANNELS-1:0] rx_valid;
	logic [serial_pkg::NUM_CHANNELS-1:0][serial_pkg::CHAR_BITS-1:0] rx_char;
	logic [serial_pkg::NUM_CHANNELS-1:0] chan_frame_err;

	tx_dispatch u_dispatch (
		.clk(clk),
		.rst_n(rst_n),
		.tx_req(tx_req),
		.tx_channel(tx_channel),
		.tx_char(tx_char),
		.busy(busy),
		.tx_ack(tx_ack),
		.load(load),
		.load_char(load_char)
	);

	for (genvar i = 0; i < serial_pkg::NUM_CHANNELS; i++) begin : g_chan
		serial_channel u_chan (
			.clk(clk),
			.rst_n(rst_n),
			.load(load[i]),
			.load_char(load_char),
			.serial_in(serial_in[i]),
			.busy(busy[i]),
			.serial_out(serial_out[i]),
			.rx_valid(rx_valid[i]),
			.rx_char(rx_char[i]),
			.frame_err(chan_frame_err[i])
		);
	end

	rx_collector u_collector (
		.clk(clk),
		.rst_n(rst_n),
		.rx_valid(rx_valid),
		.rx_char(rx_char),
		.rd_req(rd_req),
		.rd_ack(rd_ack),
		.rd_channel(rd_channel),
		.rd_char(rd_char),
		.overrun(overrun)
	);

	// Any bad stop bit on any channel latches until reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			frame_err <= 1'b0;
		end else if (|chan_frame_err) begin
			frame_err <= 1'b1;
		end
	end

endmodule

// File: verification/serial_comm_assert.sv
`timescale 1ns/1ns

module serial_comm_assert (
	input logic                                 clk,
	input logic                                 rst_n,
	input logic                                 tx_req,
	input logic                                 tx_ack,
	input logic                                 rd_req,
	input logic                                 rd_ack,
	input logic [serial_pkg::NUM_CHANNELS-1:0]  busy,
	input logic [serial_pkg::NUM_CHANNELS-1:0]  serial_out
);

	tx_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(tx_ack) |-> tx_req)
		else $error("tx_ack rose while tx_req was low");

	// The collector lets go of an entry only after the host has
	rd_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(rd_ack) |-> !$past(rd_req))
		else $error("rd_ack fell while rd_req was still high");

	idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
		(~busy & ~serial_out) == '0)
		else $error("A channel drove its serial line low while not busy");

endmodule

bind serial_comm_top serial_comm_assert u_assert (
	.clk(clk),
	.rst_n(rst_n),
	.tx_req(tx_req),
	.tx_ack(tx_ack),
	.rd_req(rd_req),
	.rd_ack(rd_ack),
	.busy(busy),
	.serial_out(serial_out)
);

// File: verification/serial_comm_tb.sv
`timescale 1ns/1ns

module serial_comm_tb;

	logic clk;
	logic rst_n;
	logic tx_req;
	logic [serial_pkg::CHAN_BITS-1:0] tx_channel;
	logic [serial_pkg::CHAR_BITS-1:0] tx_char;
	logic [serial_pkg::NUM_CHANNELS-1:0] serial_in;
	logic rd_req = 1'b0;
	logic tx_ack;
	logic rd_ack;
	logic [serial_pkg::CHAN_BITS-1:0] rd_channel;
	logic [serial_pkg::CHAR_BITS-1:0] rd_char;
	logic [serial_pkg::NUM_CHANNELS-1:0] serial_out;
	logic frame_err;
	logic overrun;

	logic [serial_pkg::NUM_CHANNELS-1:0] inject_sel; // Set bit takes the line from the testbench
	logic [serial_pkg::NUM_CHANNELS-1:0] inject_line;
	logic reading; // Host keeps a read request up while this is set
	logic [31:0] lcg_state;
	int cycle_count = 0;
	int read_count = 0;
	logic [serial_pkg::CHAR_BITS-1:0] expected_q [serial_pkg::NUM_CHANNELS][$]; // Send order per channel

	assign serial_in = (inject_sel & inject_line) | (~inject_sel & serial_out);

	serial_comm_top u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.tx_req(tx_req),
		.tx_channel(tx_channel),
		.tx_char(tx_char),
		.serial_in(serial_in),
		.rd_req(rd_req),
		.tx_ack(tx_ack),
		.rd_ack(rd_ack),
		.rd_channel(rd_channel),
		.rd_char(rd_char),
		.serial_out(serial_out),
		.frame_err(frame_err),
		.overrun(overrun)
	);

	always #2 clk = ~clk;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Characters of one channel come back in the order they went out
	function automatic logic [serial_pkg::CHAR_BITS-1:0] expected_char(
		input logic [serial_pkg::CHAN_BITS-1:0] ch);
		return expected_q[ch].pop_front();
	endfunction

	function automatic int pending_total();
		int total;
		total = 0;
		for (int ch = 0; ch < serial_pkg::NUM_CHANNELS; ch++) begin
			total += expected_q[ch].size();
		end
		return total;
	endfunction

	task automatic send_char(input logic [serial_pkg::CHAN_BITS-1:0] ch,
		input logic [serial_pkg::CHAR_BITS-1:0] c);
		@(posedge clk);
		tx_req <= 1'b1;
		tx_channel <= ch;
		tx_char <= c;
		@(posedge clk);
		while (!tx_ack) begin
			@(posedge clk); // Stalls here while the channel is still sending
		end
		expected_q[ch].push_back(c);
		tx_req <= 1'b0;
		@(posedge clk);
		while (tx_ack) begin
			@(posedge clk);
		end
	endtask

	task automatic inject_frame(input int ch, input logic [serial_pkg::CHAR_BITS-1:0] c,
		input logic stop_bit);
		logic [serial_pkg::FRAME_BITS-1:0] frame;
		frame = {stop_bit, c, 1'b0};
		for (int b = 0; b < serial_pkg::FRAME_BITS; b++) begin
			@(posedge clk);
			inject_line[ch] <= frame[b];
			repeat (serial_pkg::BIT_TICKS - 1) @(posedge clk);
		end
		@(posedge clk);
		inject_line[ch] <= 1'b1;
	endtask

	task automatic wait_drained();
		while (pending_total() != 0) begin
			@(posedge clk);
		end
	endtask

	// Reading is over once a request has waited two bit times with no answer
	task automatic wait_read_idle();
		int idle;
		idle = 0;
		while (idle < 2 * serial_pkg::BIT_TICKS) begin
			@(posedge clk);
			if (rd_req && !rd_ack) begin
				idle++;
			end else begin
				idle = 0;
			end
		end
	endtask

	always @(posedge clk) begin
		if (rd_req && rd_ack) begin
			rd_req <= 1'b0; // Entry seen, the collector frees it next
		end else if (!rd_ack) begin
			rd_req <= reading;
		end
	end

	always @(posedge clk) begin
		if (rd_req && rd_ack) begin
			read_count <= read_count + 1;
			if (expected_q[rd_channel].size() == 0) begin
				fail_run($sformatf("Channel %0d returned a character that was never sent",
					rd_channel));
			end else begin
				check_value("rd_char", 32'(rd_char), 32'(expected_char(rd_channel)));
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > 80 * serial_pkg::FRAME_BITS * serial_pkg::BIT_TICKS + 2000) begin
			fail_run($sformatf("Timeout after %0d cycles waiting on the DUT", cycle_count));
		end
	end

	initial begin
		logic [31:0] rnd;
		int first_read;
		clk = 1'b0;
		rst_n = 1'b0;
		tx_req = 1'b0;
		tx_channel = '0;
		tx_char = '0;
		inject_sel = '0;
		inject_line = '1;
		reading = 1'b0;
		lcg_state = 32'hbe591382;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		check_value("serial_out", 32'(serial_out), 32'((1 << serial_pkg::NUM_CHANNELS) - 1));
		check_value("tx_ack", 32'(tx_ack), 32'd0);
		check_value("rd_ack", 32'(rd_ack), 32'd0);
		check_value("frame_err", 32'(frame_err), 32'd0);
		check_value("overrun", 32'(overrun), 32'd0);

		reading <= 1'b1;
		for (int ch = 0; ch < serial_pkg::NUM_CHANNELS; ch++) begin
			rnd = next_random();
			send_char(ch[serial_pkg::CHAN_BITS-1:0], rnd[24 +: serial_pkg::CHAR_BITS]);
		end
		wait_drained();

		repeat (40) begin
			rnd = next_random();
			send_char(rnd[20 +: serial_pkg::CHAN_BITS], rnd[24 +: serial_pkg::CHAR_BITS]);
		end
		wait_drained();
		check_value("overrun", 32'(overrun), 32'd0);
		check_value("frame_err", 32'(frame_err), 32'd0);

		// The stop bit is judged at its middle, well before the frame has been sent
		@(posedge clk);
		inject_sel[2] <= 1'b1;
		inject_frame(2, 8'h5a, 1'b0); // Stop bit of 0
		repeat (4 * serial_pkg::BIT_TICKS) @(posedge clk);
		check_value("frame_err", 32'(frame_err), 32'd1);
		inject_sel[2] <= 1'b0;

		// Overfill with the host silent, then drain
		reading <= 1'b0;
		@(posedge clk);
		while (rd_req || rd_ack) begin
			@(posedge clk);
		end
		first_read = read_count;
		for (int n = 0; n < 24; n++) begin
			rnd = next_random();
			send_char(n[serial_pkg::CHAN_BITS-1:0], rnd[24 +: serial_pkg::CHAR_BITS]);
		end
		while (u_dut.busy != '0) begin
			@(posedge clk);
		end
		repeat (2 * serial_pkg::BIT_TICKS) @(posedge clk);
		check_value("overrun", 32'(overrun), 32'd1);
		reading <= 1'b1;
		wait_read_idle();
		if (read_count - first_read > serial_pkg::RX_DEPTH + serial_pkg::NUM_CHANNELS) begin
			fail_run("More characters were read back than the buffer and holding registers keep");
		end else if (read_count - first_read < serial_pkg::RX_DEPTH) begin
			fail_run("Fewer characters were read back than the full buffer holds");
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

// File: all.f
rtl/serial_pkg.sv
rtl/tx_dispatch.sv
rtl/serial_channel.sv
rtl/rx_collector.sv
rtl/serial_comm_top.sv
verification/serial_comm_assert.sv
verification/serial_comm_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and judges the log
cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module serial_comm_tb \
	--Mdir obj_dir -f all.f > "$build_log" 2>&1
if [ $? -ne 0 ]; then
	cat "$build_log"
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vserial_comm_tb > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^Test completed successfully$" "$sim_log"; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1
